// File: source/data_cache_cfg.svh
// Width settings for the direct-mapped write-through data cache
// Included by the package, the controller and the storage arrays
// Derived widths follow from the three base values below

`ifndef DATA_CACHE_CFG_SVH
`define DATA_CACHE_CFG_SVH

// Byte address width on both APB sides
`define DC_ADDR_WIDTH 32

// Width of one cached word, also the APB data width
`define DC_DATA_WIDTH 32

// Line index width, one word per line
`define DC_INDEX_BITS 6

// Byte offset inside a word, dropped from the lookup
`define DC_OFFSET_BITS $clog2(`DC_DATA_WIDTH / 8)

// Everything above the index and the byte offset forms the tag
`define DC_TAG_BITS (`DC_ADDR_WIDTH - `DC_INDEX_BITS - `DC_OFFSET_BITS)

// Number of cache lines
`define DC_LINES (1 << `DC_INDEX_BITS)

`endif

// File: source/data_cache_pkg.sv
// Shared types of the data cache
// Width typedefs, the APB request and response structs and the controller states
// Referenced everywhere by scoped names

`default_nettype none

`include "data_cache_cfg.svh"

package data_cache_pkg;

    // Plain vectors for the widths that carry a meaning
    typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DC_DATA_WIDTH-1:0] word_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_TAG_BITS-1:0]   tag_t;

    // ------------------------------------------------------------------------
    // APB signals, grouped by direction
    // ------------------------------------------------------------------------

    // Driven by the master, the same struct on the processor and memory side
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    // Driven by the slave, prdata only counts while pready is high
    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

    // Controller states, in the order a miss walks through them
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_SETUP,
        MEM_ACCESS,
        FILL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/data_tag_memory.sv
// Tag storage of the data cache, one tag per line
// Port 0 reads or writes and serves write lookups and refill
// Port 1 only reads and serves read lookups
// Both ports return their tag one cycle after the read strobe

`default_nettype none

`include "data_cache_cfg.svh"

module data_tag_memory (
    input  logic                  clk_i,

    // Port 0 reads or writes
    input  data_cache_pkg::index_t port0_address_i,
    input  data_cache_pkg::tag_t   port0_tag_i,
    input  logic                   port0_write_i,
    input  logic                   port0_read_i,
    output data_cache_pkg::tag_t   port0_tag_o,

    // Port 1 only reads
    input  data_cache_pkg::index_t port1_address_i,
    input  logic                   port1_read_i,
    output data_cache_pkg::tag_t   port1_tag_o
);

    // A stored tag only counts while the valid bit of its line is set
    data_cache_pkg::tag_t tag_mem [`DC_LINES];

    // A write on port 0 wins over a read in the same cycle
    always_ff @(posedge clk_i) begin
        if (port0_write_i) begin
            tag_mem[port0_address_i] <= port0_tag_i;
        end else if (port0_read_i) begin
            port0_tag_o <= tag_mem[port0_address_i];
        end
    end

    // The output holds its last value between read strobes
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_tag_o <= tag_mem[port1_address_i];
        end
    end

endmodule

`default_nettype wire

// File: source/cache_data_memory.sv
// Word storage of the data cache, one word per line
// Single port with a registered read, addressed by the lookup index
// Written on refill and on a write hit

`default_nettype none

`include "data_cache_cfg.svh"

module cache_data_memory (
    input  logic                   clk_i,
    input  data_cache_pkg::index_t address_i,
    input  logic                   write_i,
    input  logic                   read_i,
    input  data_cache_pkg::word_t  data_i,
    output data_cache_pkg::word_t  data_o
);

    // ------------------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------------------

    data_cache_pkg::word_t word_mem [`DC_LINES];

    // Write takes priority, a read in the same cycle is dropped
    // The read word appears on data_o in the next cycle
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            word_mem[address_i] <= data_i;
        end else if (read_i) begin
            data_o <= word_mem[address_i];
        end
    end

endmodule

`default_nettype wire

// File: source/cache_valid_array.sv
// Valid bits of the data cache, one per line
// Reset clears every bit and a refill sets the bit of its line
// Two registered read ports line up with the two tag memory ports

`default_nettype none

`include "data_cache_cfg.svh"

module cache_valid_array (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Refill marks a line valid
    input  logic                   set_i,
    input  data_cache_pkg::index_t set_index_i,

    // Read ports, same timing as the tag memory
    input  data_cache_pkg::index_t port0_address_i,
    input  logic                   port0_read_i,
    output logic                   port0_valid_o,
    input  data_cache_pkg::index_t port1_address_i,
    input  logic                   port1_read_i,
    output logic                   port1_valid_o
);

    logic [`DC_LINES-1:0] valid_q;

    // Reset is the only way to drop a line
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (set_i) begin
            valid_q[set_index_i] <= 1'b1;
        end
    end

    // Each read port follows its strobe, so a tag and its bit arrive together
    always_ff @(posedge clk_i) begin
        if (port0_read_i) begin
            port0_valid_o <= valid_q[port0_address_i];
        end
        if (port1_read_i) begin
            port1_valid_o <= valid_q[port1_address_i];
        end
    end

endmodule

`default_nettype wire

// File: source/cache_controller.sv
// Control FSM of the data cache
// Acts as APB slave to the processor and APB master to the backing memory
// Issues the lookup in the setup phase, compares in the access phase,
// refills on a read miss and sends every write through to memory

`default_nettype none

`include "data_cache_cfg.svh"

module cache_controller (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Processor side, cache is the slave
    input  data_cache_pkg::apb_req_t cpu_req_i,
    output data_cache_pkg::apb_rsp_t cpu_rsp_o,

    // Memory side, cache is the master
    output data_cache_pkg::apb_req_t mem_req_o,
    input  data_cache_pkg::apb_rsp_t mem_rsp_i,

    // Lookup strobes to the storage arrays
    output data_cache_pkg::index_t   lookup_index_o,
    output logic                     rd_lookup_o,
    output logic                     wr_lookup_o,
    output logic                     data_read_o,

    // Refill of tag and valid bit
    output logic                     fill_o,
    output data_cache_pkg::tag_t     fill_tag_o,

    // Data memory write
    output logic                     data_write_o,
    output data_cache_pkg::word_t    data_wdata_o,

    // Registered lookup results
    input  data_cache_pkg::tag_t     rd_tag_i,
    input  logic                     rd_valid_i,
    input  data_cache_pkg::tag_t     wr_tag_i,
    input  logic                     wr_valid_i,
    input  data_cache_pkg::word_t    data_rdata_i
);

    data_cache_pkg::ctrl_state_t state_q;
    data_cache_pkg::ctrl_state_t state_d;
    data_cache_pkg::tag_t        addr_tag;
    data_cache_pkg::word_t       fill_word_q;
    logic                        setup_phase;
    logic                        read_hit;
    logic                        write_hit;
    logic                        write_hit_q;
    logic                        mem_done;

    // ------------------------------------------------------------------------
    // Address split and hit compare
    // ------------------------------------------------------------------------

    // The processor holds its request until pready, so it is used directly
    assign addr_tag       = cpu_req_i.paddr[`DC_ADDR_WIDTH-1 -: `DC_TAG_BITS];
    assign lookup_index_o = cpu_req_i.paddr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign setup_phase    = cpu_req_i.psel & ~cpu_req_i.penable;

    // Reads look up through port 1, writes through port 0
    assign read_hit  = rd_valid_i & (rd_tag_i == addr_tag);
    assign write_hit = wr_valid_i & (wr_tag_i == addr_tag);

    // Memory access phase finishing this cycle
    assign mem_done = (state_q == data_cache_pkg::MEM_ACCESS) & mem_rsp_i.pready;

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            data_cache_pkg::IDLE: begin
                if (setup_phase) begin
                    state_d = data_cache_pkg::LOOKUP;
                end
            end
            // A read hit is answered here, anything else needs the memory
            data_cache_pkg::LOOKUP: begin
                if (!cpu_req_i.pwrite && read_hit) begin
                    state_d = data_cache_pkg::IDLE;
                end else begin
                    state_d = data_cache_pkg::MEM_SETUP;
                end
            end
            data_cache_pkg::MEM_SETUP: begin
                state_d = data_cache_pkg::MEM_ACCESS;
            end
            // Wait states of the memory keep the FSM here
            data_cache_pkg::MEM_ACCESS: begin
                if (mem_rsp_i.pready) begin
                    state_d = cpu_req_i.pwrite ? data_cache_pkg::DONE : data_cache_pkg::FILL;
                end
            end
            data_cache_pkg::FILL: begin
                state_d = data_cache_pkg::DONE;
            end
            default: begin
                state_d = data_cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= data_cache_pkg::IDLE;
            write_hit_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Write hit is remembered until the write-through completes
            if (state_q == data_cache_pkg::LOOKUP) begin
                write_hit_q <= write_hit;
            end
        end
    end

    // Memory word kept for the refill and the late read response
    always_ff @(posedge clk_i) begin
        if (mem_done) begin
            fill_word_q <= mem_rsp_i.prdata;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    // Lookups start only from IDLE, during the processor setup phase
    assign rd_lookup_o = (state_q == data_cache_pkg::IDLE) & setup_phase & ~cpu_req_i.pwrite;
    assign wr_lookup_o = (state_q == data_cache_pkg::IDLE) & setup_phase & cpu_req_i.pwrite;
    assign data_read_o = (state_q == data_cache_pkg::IDLE) & setup_phase;

    assign fill_o     = (state_q == data_cache_pkg::FILL);
    assign fill_tag_o = addr_tag;

    // A write hit updates the line as the memory write completes
    assign data_write_o = fill_o | (mem_done & cpu_req_i.pwrite & write_hit_q);
    assign data_wdata_o = fill_o ? fill_word_q : cpu_req_i.pwdata;

    // Memory request copies the held processor fields
    assign mem_req_o.psel    = (state_q == data_cache_pkg::MEM_SETUP) |
                               (state_q == data_cache_pkg::MEM_ACCESS);
    assign mem_req_o.penable = (state_q == data_cache_pkg::MEM_ACCESS);
    assign mem_req_o.pwrite  = cpu_req_i.pwrite;
    assign mem_req_o.paddr   = cpu_req_i.paddr;
    assign mem_req_o.pwdata  = cpu_req_i.pwdata;

    // Hit data comes straight from the data memory, miss data from the capture
    assign cpu_rsp_o.pready = ((state_q == data_cache_pkg::LOOKUP) & ~cpu_req_i.pwrite & read_hit) |
                              (state_q == data_cache_pkg::DONE);
    assign cpu_rsp_o.prdata = (state_q == data_cache_pkg::LOOKUP) ? data_rdata_i : fill_word_q;

endmodule

`default_nettype wire

// File: source/data_cache_top.sv
// Top level of the direct-mapped write-through data cache
// Processor APB slave on one side, memory APB master on the other
// Connects the controller to the tag, valid and data storage

`default_nettype none

module data_cache_top (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  data_cache_pkg::apb_req_t cpu_req_i,
    output data_cache_pkg::apb_rsp_t cpu_rsp_o,
    output data_cache_pkg::apb_req_t mem_req_o,
    input  data_cache_pkg::apb_rsp_t mem_rsp_i
);

    data_cache_pkg::index_t lookup_index;
    data_cache_pkg::tag_t   fill_tag;
    data_cache_pkg::tag_t   rd_tag;
    data_cache_pkg::tag_t   wr_tag;
    data_cache_pkg::word_t  data_wdata;
    data_cache_pkg::word_t  data_rdata;
    logic                   rd_lookup;
    logic                   wr_lookup;
    logic                   data_read;
    logic                   data_write;
    logic                   fill;
    logic                   rd_valid;
    logic                   wr_valid;

    cache_controller u_controller (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_rsp_o      (cpu_rsp_o),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .lookup_index_o (lookup_index),
        .rd_lookup_o    (rd_lookup),
        .wr_lookup_o    (wr_lookup),
        .data_read_o    (data_read),
        .fill_o         (fill),
        .fill_tag_o     (fill_tag),
        .data_write_o   (data_write),
        .data_wdata_o   (data_wdata),
        .rd_tag_i       (rd_tag),
        .rd_valid_i     (rd_valid),
        .wr_tag_i       (wr_tag),
        .wr_valid_i     (wr_valid),
        .data_rdata_i   (data_rdata)
    );

    // Port 0 shares the write lookup with the refill write
    data_tag_memory u_tag_memory (
        .clk_i           (clk_i),
        .port0_address_i (lookup_index),
        .port0_tag_i     (fill_tag),
        .port0_write_i   (fill),
        .port0_read_i    (wr_lookup),
        .port0_tag_o     (wr_tag),
        .port1_address_i (lookup_index),
        .port1_read_i    (rd_lookup),
        .port1_tag_o     (rd_tag)
    );

    // Valid ports follow the same strobes as the tag ports
    cache_valid_array u_valid_array (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .set_i           (fill),
        .set_index_i     (lookup_index),
        .port0_address_i (lookup_index),
        .port0_read_i    (wr_lookup),
        .port0_valid_o   (wr_valid),
        .port1_address_i (lookup_index),
        .port1_read_i    (rd_lookup),
        .port1_valid_o   (rd_valid)
    );

    cache_data_memory u_data_memory (
        .clk_i     (clk_i),
        .address_i (lookup_index),
        .write_i   (data_write),
        .read_i    (data_read),
        .data_i    (data_wdata),
        .data_o    (data_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/apb_memory_model.sv
// Backing memory for the data cache testbench, seen by the cache as an APB slave
// Each access phase takes zero to three random wait states
// Contents are preloaded word by word through the load port before any transfer
// Completed reads and writes are counted so the testbench can spot cache misses

`default_nettype none

module apb_memory_model #(
    parameter int WORDS = 1024
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  data_cache_pkg::apb_req_t req_i,
    output data_cache_pkg::apb_rsp_t rsp_o,
    input  logic                     load_i,
    input  logic [$clog2(WORDS)-1:0] load_addr_i,
    input  data_cache_pkg::word_t    load_data_i,
    output int                       read_count_o,
    output int                       write_count_o
);

    localparam int AW = $clog2(WORDS);

    data_cache_pkg::word_t mem_q [WORDS];
    int unsigned           wait_q;
    logic [AW-1:0]         word_addr;
    logic                  access;
    logic                  ready;

    // Only the low word address bits reach the array, higher bits wrap
    assign word_addr = req_i.paddr[AW+1:2];
    assign access    = req_i.psel & req_i.penable;
    assign ready     = access & (wait_q == 0);

    assign rsp_o.pready = ready;
    assign rsp_o.prdata = mem_q[word_addr];

    // Preload and bus writes share one port, preload first
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end else if (ready && req_i.pwrite) begin
            mem_q[word_addr] <= req_i.pwdata;
        end
    end

    // The wait count is drawn in the setup phase and runs down in the access phase
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wait_q        <= 0;
            read_count_o  <= 0;
            write_count_o <= 0;
        end else begin
            if (req_i.psel && !req_i.penable) begin
                wait_q <= $urandom_range(3, 0);
            end else if (access && wait_q != 0) begin
                wait_q <= wait_q - 1;
            end
            if (ready && req_i.pwrite) begin
                write_count_o <= write_count_o + 1;
            end
            if (ready && !req_i.pwrite) begin
                read_count_o <= read_count_o + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_data_cache.sv
// Directed testbench of the direct-mapped write-through data cache
// Drives the processor APB side, serves the memory side with a model
// and checks every response against a reference copy of memory, tags and valid bits

`default_nettype none

`include "data_cache_cfg.svh"

module tb_data_cache;

    localparam int unsigned SEED           = 32'h0e467df8;
    localparam int          MEM_WORDS      = 1024;
    localparam int          MEM_AW         = $clog2(MEM_WORDS);
    localparam int          TIMEOUT_CYCLES = 64;
    localparam int          SWEEP_OPS      = 400;

    logic                     clk_i;
    logic                     reset_i;
    data_cache_pkg::apb_req_t cpu_req;
    data_cache_pkg::apb_rsp_t cpu_rsp;
    data_cache_pkg::apb_req_t mem_req;
    data_cache_pkg::apb_rsp_t mem_rsp;
    logic                     load;
    logic [MEM_AW-1:0]        load_addr;
    data_cache_pkg::word_t    load_data;
    int                       mem_reads;
    int                       mem_writes;

    // Reference state: memory contents plus the tag and valid bit of each line
    data_cache_pkg::word_t ref_mem [MEM_WORDS];
    data_cache_pkg::tag_t  ref_tag [`DC_LINES];
    logic                  ref_valid [`DC_LINES];
    int                    predicted_misses;
    int                    value_errors;
    int                    timeout_errors;

    data_cache_top dut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    apb_memory_model #(.WORDS(MEM_WORDS)) mem_model (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (mem_req),
        .rsp_o         (mem_rsp),
        .load_i        (load),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .read_count_o  (mem_reads),
        .write_count_o (mem_writes)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input data_cache_pkg::word_t got,
                              input data_cache_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Processor APB master
    // ------------------------------------------------------------------------

    // Samples pready at the falling edge, counting access cycles from one
    task automatic wait_ready(output data_cache_pkg::word_t data, output int cycles);
        cycles = 0;
        data   = '0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!cpu_rsp.pready && cycles < TIMEOUT_CYCLES);
        if (cpu_rsp.pready) begin
            data = cpu_rsp.prdata;
        end else begin
            timeout_errors++;
            $display("Timeout at %0t: the cache gave no pready within %0d cycles",
                     $time, TIMEOUT_CYCLES);
        end
    endtask

    // One setup cycle, then the access phase is held until pready
    task automatic drive_transfer(input logic write, input data_cache_pkg::addr_t addr,
                                  input data_cache_pkg::word_t wdata,
                                  output data_cache_pkg::word_t rdata, output int cycles);
        data_cache_pkg::apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk_i);
        cpu_req <= req;
        req.penable = 1'b1;
        @(posedge clk_i);
        cpu_req <= req;
        wait_ready(rdata, cycles);
        // The transfer completes on this edge and the bus goes idle
        @(posedge clk_i);
        cpu_req <= '0;
    endtask

    task automatic apb_read(input data_cache_pkg::addr_t addr,
                            output data_cache_pkg::word_t data, output int cycles);
        drive_transfer(1'b0, addr, '0, data, cycles);
    endtask

    task automatic apb_write(input data_cache_pkg::addr_t addr,
                             input data_cache_pkg::word_t data);
        data_cache_pkg::word_t unused_data;
        int                    unused_cycles;
        drive_transfer(1'b1, addr, data, unused_data, unused_cycles);
    endtask

    // ------------------------------------------------------------------------
    // Reference model and checked accesses
    // ------------------------------------------------------------------------

    // Word address from a 4-bit tag and a 6-bit line index
    function automatic data_cache_pkg::addr_t make_addr(input int tag, input int index);
        return data_cache_pkg::addr_t'({tag[3:0], index[5:0], 2'b00});
    endfunction

    // A read misses unless the line is valid with the same tag, a miss fills the line
    task automatic read_and_check(input data_cache_pkg::addr_t addr, output int cycles);
        data_cache_pkg::word_t  got;
        data_cache_pkg::index_t line;
        data_cache_pkg::tag_t   tag;
        logic                   miss;
        int                     reads_before;
        line = addr[7:2];
        tag  = addr[31:8];
        miss = !ref_valid[line] || ref_tag[line] != tag;
        ref_valid[line] = 1'b1;
        ref_tag[line]   = tag;
        predicted_misses += miss ? 1 : 0;
        reads_before = mem_reads;
        apb_read(addr, got, cycles);
        check_word($sformatf("cpu_rsp_o.prdata at %h", addr), got, ref_mem[addr[MEM_AW+1:2]]);
        check_count("memory read count", mem_reads - reads_before, miss ? 1 : 0);
    endtask

    // Every write reaches memory once and never allocates a line
    task automatic write_and_check(input data_cache_pkg::addr_t addr,
                                   input data_cache_pkg::word_t data);
        int reads_before;
        int writes_before;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        ref_mem[addr[MEM_AW+1:2]] = data;
        apb_write(addr, data);
        check_count("memory write count", mem_writes - writes_before, 1);
        check_count("memory read count", mem_reads - reads_before, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int i = 0; i < `DC_LINES; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // Memory and reference start from the same random words
    task automatic preload_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = $urandom();
            @(posedge clk_i);
            load      <= 1'b1;
            load_addr <= MEM_AW'(i);
            load_data <= ref_mem[i];
        end
        @(posedge clk_i);
        load <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_miss_then_hit();
        int cycles;
        read_and_check(make_addr(3, 17), cycles);
        read_and_check(make_addr(3, 17), cycles);
    endtask

    // A hit answers in the first access cycle, a miss needs the memory
    task automatic test_hit_latency();
        int cycles;
        read_and_check(make_addr(7, 40), cycles);
        check_count("miss slower than one cycle", int'(cycles > 1), 1);
        read_and_check(make_addr(7, 40), cycles);
        check_count("cpu_rsp_o.pready cycle of a hit", cycles, 1);
    endtask

    task automatic test_write_through();
        int cycles;
        read_and_check(make_addr(2, 5), cycles);
        write_and_check(make_addr(2, 5), 32'h5a5a_0f0f);
        read_and_check(make_addr(2, 5), cycles);
        // Evicting the line proves that memory holds the written word too
        read_and_check(make_addr(9, 5), cycles);
        read_and_check(make_addr(2, 5), cycles);
        write_and_check(make_addr(2, 6), 32'h1357_9bdf);
        read_and_check(make_addr(2, 6), cycles);
    endtask

    // Same index, different tags, so every read misses
    task automatic test_conflict();
        int cycles;
        repeat (3) begin
            read_and_check(make_addr(5, 9), cycles);
            read_and_check(make_addr(6, 9), cycles);
        end
    endtask

    task automatic test_reset();
        int cycles;
        read_and_check(make_addr(3, 17), cycles);
        apply_reset();
        read_and_check(make_addr(3, 17), cycles);
    endtask

    // Sixteen tags over sixteen lines give a mix of hits, conflicts and write misses
    task automatic test_random_sweep();
        data_cache_pkg::addr_t addr;
        int                    cycles;
        int                    reads_start;
        int                    misses_start;
        reads_start  = mem_reads;
        misses_start = predicted_misses;
        for (int n = 0; n < SWEEP_OPS; n++) begin
            addr = make_addr($urandom_range(15, 0), $urandom_range(15, 0));
            if ($urandom_range(1, 0) == 1) begin
                write_and_check(addr, $urandom());
            end else begin
                read_and_check(addr, cycles);
            end
        end
        check_count("memory reads over the sweep", mem_reads - reads_start,
                    predicted_misses - misses_start);
    endtask

    initial begin
        value_errors     = 0;
        timeout_errors   = 0;
        predicted_misses = 0;
        reset_i          = 1'b0;
        cpu_req          = '0;
        load             = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        void'($urandom(SEED));
        apply_reset();
        preload_memory();
        test_miss_then_hit();
        test_hit_latency();
        test_write_through();
        test_conflict();
        test_reset();
        test_random_sweep();
        $display("Result: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/data_cache_pkg.sv
source/data_tag_memory.sv
source/cache_data_memory.sv
source/cache_valid_array.sv
source/cache_controller.sv
source/data_cache_top.sv
testbench/apb_memory_model.sv
testbench/tb_data_cache.sv

// File: Makefile
# Verilator flow for the data cache
# Any variable can be overridden on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_data_cache
RTL_TOP    ?= data_cache_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_TEXT  ?= all tests passed

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run the testbench, the exit status follows the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
